// ==== logic/fir_pkg.sv ====
/*
 * FIR subsystem shared definitions.
 * Widths, vector types, AXI4-Lite and stream structs,
 * register map and control FSM states.
 */
package fir_pkg;

    localparam int DATA_WIDTH = 16;
    localparam int COEF_WIDTH = 18;
    localparam int CH_NUM     = 2;
    localparam int MAX_TAPS   = 32;
    localparam int ACC_WIDTH  = DATA_WIDTH + COEF_WIDTH + $clog2(MAX_TAPS);

    typedef logic signed [DATA_WIDTH-1:0] sample_t;
    typedef logic signed [COEF_WIDTH-1:0] coef_t;
    typedef logic signed [ACC_WIDTH-1:0]  acc_t;
    typedef logic [5:0]                   shift_t;
    typedef logic [4:0]                   tap_idx_t;

    // ******************************
    // AXI4-Lite
    typedef struct packed {
        logic [11:0] awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [11:0] araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axil_rsp_t;

    // ******************************
    // sample stream
    typedef struct packed {
        logic                     valid;
        sample_t [CH_NUM-1:0]     data;
    } smp_beat_t;

    typedef struct packed {
        logic                     valid;
        sample_t [CH_NUM-1:0]     data;
    } out_beat_t;

    // ******************************
    // register map
    localparam logic [11:0] REG_CTRL      = 12'h000; // enable [0], shift [13:8].
    localparam logic [11:0] REG_STATUS    = 12'h004; // sat flag [0], count [31:16].
    localparam logic [11:0] REG_COEF_BASE = 12'h100; // tap k at base + 4k.

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic [1:0] {
        IDLE,
        RESP,
        READ
    } csr_state_e;

endpackage

// ==== logic/fir_csr.sv ====
/*
 * AXI4-Lite control slave.
 * Write and read FSMs, control register, sticky saturation
 * flag, output sample counter and coefficient access.
 */
`timescale 1ns/10ps

module fir_csr import fir_pkg::*; #(
    parameter int TAP_NUM = 8
) (
    input  logic      clk_i,
    input  logic      rst_i,
    input  axil_req_t axil_req_i,
    output axil_rsp_t axil_rsp_o,
    output logic      coef_we_o,
    output tap_idx_t  coef_waddr_o,
    output coef_t     coef_wdata_o,
    output tap_idx_t  coef_raddr_o,
    input  coef_t     coef_rdata_i,
    output logic      enable_o,
    output shift_t    shift_o,
    input  logic      out_fire_i,
    input  logic      sat_i
);

    csr_state_e  wr_state;
    csr_state_e  rd_state;
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [1:0]  rresp;
    logic [31:0] rdata;
    logic        sat_flag;
    logic [15:0] out_cnt;
    logic        wr_ctrl;
    logic        wr_status;
    logic        wr_coef;
    logic        rd_coef;

    function automatic logic is_coef(logic [11:0] addr);
        logic [11:0] off;
        off = addr - REG_COEF_BASE;
        return (addr >= REG_COEF_BASE) && (off[11:2] < 10'(TAP_NUM));
    endfunction

    function automatic tap_idx_t coef_idx(logic [11:0] addr);
        logic [11:0] off;
        off = addr - REG_COEF_BASE;
        return off[6:2];
    endfunction

    assign wr_ctrl   = (axil_req_i.awaddr == REG_CTRL);
    assign wr_status = (axil_req_i.awaddr == REG_STATUS);
    assign wr_coef   = is_coef(axil_req_i.awaddr);
    assign rd_coef   = is_coef(axil_req_i.araddr);

    // bank readback registers on the AR handshake edge.
    assign coef_raddr_o = coef_idx(axil_req_i.araddr);

    // ******************************
    // write channel
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_state  <= IDLE;
            awready   <= 1'b0;
            wready    <= 1'b0;
            bvalid    <= 1'b0;
            coef_we_o <= 1'b0;
            enable_o  <= 1'b0;
            shift_o   <= '0;
            sat_flag  <= 1'b0;
        end else begin
            coef_we_o <= 1'b0;
            case (wr_state)
                IDLE: begin
                    if (awready) begin
                        awready  <= 1'b0;
                        wready   <= 1'b0;
                        bvalid   <= 1'b1;
                        wr_state <= RESP;
                        if (wr_ctrl) begin
                            if (axil_req_i.wstrb[0]) enable_o <= axil_req_i.wdata[0];
                            if (axil_req_i.wstrb[1]) shift_o <= axil_req_i.wdata[13:8];
                        end else if (wr_status) begin
                            if (axil_req_i.wstrb[0] && axil_req_i.wdata[0]) sat_flag <= 1'b0;
                        end else if (wr_coef) begin
                            coef_we_o <= 1'b1;
                        end
                    end else if (axil_req_i.awvalid && axil_req_i.wvalid) begin
                        awready <= 1'b1; // both channels taken together.
                        wready  <= 1'b1;
                    end
                end
                RESP: begin
                    if (axil_req_i.bready) begin
                        bvalid   <= 1'b0;
                        wr_state <= IDLE;
                    end
                end
                default: wr_state <= IDLE;
            endcase
            if (sat_i) sat_flag <= 1'b1; // new clip wins over clear.
        end
    end

    always_ff @(posedge clk_i) begin
        if (awready) begin
            coef_waddr_o <= coef_idx(axil_req_i.awaddr);
            coef_wdata_o <= axil_req_i.wdata[COEF_WIDTH-1:0];
            bresp        <= (wr_ctrl || wr_status || wr_coef) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            out_cnt <= '0;
        end else if (out_fire_i) begin
            out_cnt <= out_cnt + 16'd1; // wraps.
        end
    end

    // ******************************
    // read channel
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_state <= IDLE;
            arready  <= 1'b0;
            rvalid   <= 1'b0;
        end else begin
            case (rd_state)
                IDLE: begin
                    if (arready) begin
                        arready <= 1'b0;
                        if (rd_coef) begin
                            rd_state <= READ; // wait for bank readback.
                        end else begin
                            rvalid   <= 1'b1;
                            rd_state <= RESP;
                        end
                    end else if (axil_req_i.arvalid) begin
                        arready <= 1'b1;
                    end
                end
                READ: begin
                    rvalid   <= 1'b1;
                    rd_state <= RESP;
                end
                RESP: begin
                    if (axil_req_i.rready) begin
                        rvalid   <= 1'b0;
                        rd_state <= IDLE;
                    end
                end
                default: rd_state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (arready) begin
            rresp <= RESP_OKAY;
            rdata <= '0;
            if (axil_req_i.araddr == REG_CTRL) begin
                rdata <= {18'b0, shift_o, 7'b0, enable_o};
            end else if (axil_req_i.araddr == REG_STATUS) begin
                rdata <= {out_cnt, 15'b0, sat_flag};
            end else if (!rd_coef) begin
                rresp <= RESP_SLVERR;
            end
        end else if (rd_state == READ) begin
            rdata <= {{(32-COEF_WIDTH){coef_rdata_i[COEF_WIDTH-1]}}, coef_rdata_i};
        end
    end

    assign axil_rsp_o = '{
        awready: awready,
        wready:  wready,
        bresp:   bresp,
        bvalid:  bvalid,
        arready: arready,
        rdata:   rdata,
        rresp:   rresp,
        rvalid:  rvalid
    };

endmodule

// ==== logic/fir_coef_bank.sv ====
/*
 * Coefficient register bank.
 * One write port, one registered readback port,
 * all taps presented in parallel.
 */
`timescale 1ns/10ps

module fir_coef_bank import fir_pkg::*; #(
    parameter int TAP_NUM = 8
) (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                we_i,
    input  tap_idx_t            waddr_i,
    input  coef_t               wdata_i,
    input  tap_idx_t            raddr_i,
    output coef_t               rdata_o,
    output coef_t [TAP_NUM-1:0] coefs_o
);

    localparam int IDX_W = $clog2(TAP_NUM);

    // taps live directly in the output vector.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            coefs_o <= '0;
        end else if (we_i && (waddr_i < TAP_NUM)) begin
            coefs_o[waddr_i[IDX_W-1:0]] <= wdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (raddr_i < TAP_NUM) begin
            rdata_o <= coefs_o[raddr_i[IDX_W-1:0]];
        end else begin
            rdata_o <= '0; // out of range reads as zero.
        end
    end

endmodule

// ==== logic/fir_channel.sv ====
/*
 * One FIR channel.
 * Delay line, registered tap products and a
 * pipelined binary adder tree.
 */
`timescale 1ns/10ps

module fir_channel import fir_pkg::*; #(
    parameter int TAP_NUM = 8
) (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                valid_i,
    input  sample_t             sample_i,
    input  coef_t [TAP_NUM-1:0] coefs_i,
    output acc_t                acc_o
);

    localparam int PROD_W = DATA_WIDTH + COEF_WIDTH;
    localparam int HALF   = TAP_NUM / 2;

    sample_t [TAP_NUM-1:0]    dly;
    logic signed [PROD_W-1:0] prod [TAP_NUM];
    acc_t                     node [TAP_NUM-1];

    // ******************************
    // delay line, newest sample at tap 0
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dly <= '0;
        end else if (valid_i) begin
            dly[0] <= sample_i;
            for (int k = 1; k < TAP_NUM; k++) begin
                dly[k] <= dly[k-1];
            end
        end
    end

    // ******************************
    // tap products, every cycle
    always_ff @(posedge clk_i) begin
        for (int k = 0; k < TAP_NUM; k++) begin
            prod[k] <= $signed(dly[k]) * $signed(coefs_i[k]);
        end
    end

    // ******************************
    // adder tree
    // nodes below HALF add product pairs, the rest add node pairs.
    // each level is one register stage, root is the last node.
    always_ff @(posedge clk_i) begin
        for (int n = 0; n < TAP_NUM - 1; n++) begin
            if (n < HALF) begin
                node[n] <= acc_t'(prod[2*n]) + acc_t'(prod[2*n+1]);
            end else begin
                node[n] <= node[2*(n-HALF)] + node[2*(n-HALF)+1];
            end
        end
    end

    assign acc_o = node[TAP_NUM-2]; // full precision sum.

endmodule

// ==== logic/fir_out_scale.sv ====
/*
 * Output scaler.
 * Round, shift and saturate each accumulator to sample width,
 * flag clipping and register the output beat.
 */
`timescale 1ns/10ps

module fir_out_scale import fir_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_i,
    input  acc_t [CH_NUM-1:0] acc_i,
    input  shift_t            shift_i,
    input  logic              valid_i,
    output out_beat_t         beat_o,
    output logic              sat_o
);

    localparam int RND_W = ACC_WIDTH + 1;
    localparam logic signed [RND_W-1:0] SMP_MAX = 2**(DATA_WIDTH-1) - 1;
    localparam logic signed [RND_W-1:0] SMP_MIN = -(2**(DATA_WIDTH-1));

    logic signed [RND_W-1:0] half;
    sample_t [CH_NUM-1:0]    res;
    logic [CH_NUM-1:0]       clip;
    sample_t [CH_NUM-1:0]    data_q;
    logic                    valid_q;
    logic                    sat_q;

    // half an LSB at the shift position.
    assign half = (shift_i == '0) ? '0 : (RND_W'(1) << (shift_i - 6'd1));

    for (genvar ch = 0; ch < CH_NUM; ch++) begin : g_ch
        logic signed [RND_W-1:0] rnd;
        logic signed [RND_W-1:0] shd;

        assign rnd      = $signed({acc_i[ch][ACC_WIDTH-1], acc_i[ch]}) + half; // no wrap.
        assign shd      = rnd >>> shift_i;
        assign clip[ch] = (shd > SMP_MAX) || (shd < SMP_MIN);
        assign res[ch]  = (shd > SMP_MAX) ? SMP_MAX[DATA_WIDTH-1:0] :
                          (shd < SMP_MIN) ? SMP_MIN[DATA_WIDTH-1:0] : shd[DATA_WIDTH-1:0];
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
            sat_q   <= 1'b0;
        end else begin
            valid_q <= valid_i;
            sat_q   <= valid_i && (|clip); // only real beats count.
        end
    end

    always_ff @(posedge clk_i) begin
        data_q <= res;
    end

    assign beat_o = '{valid: valid_q, data: data_q};
    assign sat_o  = sat_q;

endmodule

// ==== logic/fir_top.sv ====
/*
 * FIR subsystem top level.
 * Control slave, coefficient bank, per-channel filters,
 * output scaler and the valid pipeline.
 */
`timescale 1ns/10ps

module fir_top import fir_pkg::*; #(
    parameter int TAP_NUM = 8
) (
    input  logic      clk_i,
    input  logic      rst_i,
    input  axil_req_t axil_req_i,
    output axil_rsp_t axil_rsp_o,
    input  smp_beat_t smp_i,
    output out_beat_t out_o
);

    // delay line, product stage and tree levels.
    localparam int VLD_DEPTH = 2 + $clog2(TAP_NUM);

    if (TAP_NUM < 2 || TAP_NUM > MAX_TAPS || $countones(TAP_NUM) != 1) begin : g_tap_num_err
        $error("TAP_NUM must be a power of two from 2 to 32.");
    end

    logic                  coef_we;
    tap_idx_t              coef_waddr;
    coef_t                 coef_wdata;
    tap_idx_t              coef_raddr;
    coef_t                 coef_rdata;
    coef_t [TAP_NUM-1:0]   coefs;
    logic                  enable;
    shift_t                shift;
    logic                  sat;
    logic                  vld_in;
    logic [VLD_DEPTH-1:0]  vld_pipe;
    acc_t [CH_NUM-1:0]     acc;

    assign vld_in = smp_i.valid & enable; // disabled beats are dropped.

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[VLD_DEPTH-2:0], vld_in};
        end
    end

    fir_csr #(.TAP_NUM(TAP_NUM)) csr0 (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .axil_req_i  (axil_req_i),
        .axil_rsp_o  (axil_rsp_o),
        .coef_we_o   (coef_we),
        .coef_waddr_o(coef_waddr),
        .coef_wdata_o(coef_wdata),
        .coef_raddr_o(coef_raddr),
        .coef_rdata_i(coef_rdata),
        .enable_o    (enable),
        .shift_o     (shift),
        .out_fire_i  (out_o.valid),
        .sat_i       (sat)
    );

    fir_coef_bank #(.TAP_NUM(TAP_NUM)) coef_bank0 (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .we_i   (coef_we),
        .waddr_i(coef_waddr),
        .wdata_i(coef_wdata),
        .raddr_i(coef_raddr),
        .rdata_o(coef_rdata),
        .coefs_o(coefs)
    );

    for (genvar ch = 0; ch < CH_NUM; ch++) begin : g_ch
        fir_channel #(.TAP_NUM(TAP_NUM)) channel0 (
            .clk_i   (clk_i),
            .rst_i   (rst_i),
            .valid_i (vld_in),
            .sample_i(smp_i.data[ch]),
            .coefs_i (coefs),
            .acc_o   (acc[ch])
        );
    end

    fir_out_scale out_scale0 (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .acc_i  (acc),
        .shift_i(shift),
        .valid_i(vld_pipe[VLD_DEPTH-1]),
        .beat_o (out_o),
        .sat_o  (sat)
    );

endmodule

// ==== dv/fir_tb.sv ====
/*
 * FIR subsystem testbench.
 * AXI4-Lite master tasks, stimulus table, LCG, reference model,
 * output monitor and result reporting.
 */
`timescale 1ns/10ps

module fir_tb import fir_pkg::*; ();

    localparam int TAPS          = 8;
    localparam int LATENCY       = 3 + $clog2(TAPS);
    localparam int N_TESTS       = 6;
    localparam int AXI_TIMEOUT   = 100;
    localparam int DRAIN_TIMEOUT = 200;

    typedef enum int {SRC_IMPULSE, SRC_STEP, SRC_RAND, SRC_RAND_GAP} src_e;

    logic      clk_i = 1'b0;
    logic      rst_i;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    smp_beat_t smp;
    out_beat_t out_o;

    string       name_tab [N_TESTS];
    int          coef_tab [N_TESTS][TAPS];
    int          shift_tab [N_TESTS];
    int          en_tab [N_TESTS];
    src_e        src_tab [N_TESTS];
    int          count_tab [N_TESTS];
    int          model_dly [CH_NUM][TAPS];
    int          exp_ch0 [$];
    int          exp_ch1 [$];
    int          exp_cyc [$];
    logic [31:0] lcg_state = 32'hcc5c;
    int          cycle = 0;
    int          out_beats = 0;
    int          errors = 0;
    int          test_errors;
    int          tests_run = 0;
    int          tests_failed = 0;
    string       cur_test = "reset";
    logic [31:0] rd_data;
    logic [1:0]  resp;

    fir_top #(.TAP_NUM(TAPS)) dut0 (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .axil_req_i(axil_req),
        .axil_rsp_o(axil_rsp),
        .smp_i     (smp),
        .out_o     (out_o)
    );

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) cycle <= cycle + 1;

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(string what, logic signed [31:0] exp, logic signed [31:0] act);
        assert (exp === act) else begin
            $display("** Error %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic abort_run(string what);
        $display("%s timed out in test %s at cycle %0d", what, cur_test, cycle);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    // ******************************
    // AXI4-Lite master
    task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                              output logic [1:0] bresp);
        int n;
        int aw_cycles;
        aw_cycles        = 0;
        axil_req.awaddr  = addr;
        axil_req.wdata   = data;
        axil_req.wstrb   = 4'hf;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid  = 1'b1;
        axil_req.bready  = 1'b1;
        for (n = 0; n < AXI_TIMEOUT && !axil_rsp.bvalid; n++) begin
            @(posedge clk_i);
            #2;
            if (axil_rsp.awready && axil_rsp.wready) aw_cycles++;
        end
        if (!axil_rsp.bvalid) abort_run("AXI write response");
        check_value("awready cycles", 1, aw_cycles);
        bresp            = axil_rsp.bresp;
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        @(posedge clk_i);
        #2;
        axil_req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [11:0] addr, output logic [31:0] data,
                             output logic [1:0] rresp);
        int n;
        int ar_cycles;
        ar_cycles        = 0;
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        axil_req.rready  = 1'b1;
        for (n = 0; n < AXI_TIMEOUT && !axil_rsp.rvalid; n++) begin
            @(posedge clk_i);
            #2;
            if (axil_rsp.arready) ar_cycles++;
        end
        if (!axil_rsp.rvalid) abort_run("AXI read response");
        check_value("arready cycles", 1, ar_cycles);
        data             = axil_rsp.rdata;
        rresp            = axil_rsp.rresp;
        axil_req.arvalid = 1'b0;
        @(posedge clk_i);
        #2;
        axil_req.rready = 1'b0;
    endtask

    // ******************************
    // reference model
    task automatic model_shift(int s0, int s1);
        for (int k = TAPS - 1; k > 0; k--) begin
            model_dly[0][k] = model_dly[0][k-1];
            model_dly[1][k] = model_dly[1][k-1];
        end
        model_dly[0][0] = s0; // newest at tap 0.
        model_dly[1][0] = s1;
    endtask

    function automatic int model_out(int ch, int t);
        longint acc;
        int     sh;
        acc = 0;
        sh  = shift_tab[t];
        for (int k = 0; k < TAPS; k++) begin
            acc += longint'(model_dly[ch][k]) * longint'(coef_tab[t][k]);
        end
        if (sh > 0) acc += longint'(1) << (sh - 1); // round half up.
        acc = acc >>> sh;
        if (acc > 32767) acc = 32767;
        else if (acc < -32768) acc = -32768;
        return int'(acc);
    endfunction

    always @(negedge clk_i) begin : out_monitor
        sample_t got0;
        sample_t got1;
        int      issued;
        if (!rst_i && out_o.valid) begin
            assert (exp_cyc.size() != 0) else begin
                $display("unexpected output beat in test %s at cycle %0d", cur_test, cycle);
                errors++;
            end
            if (exp_cyc.size() != 0) begin
                got0   = out_o.data[0];
                got1   = out_o.data[1];
                issued = exp_cyc.pop_front();
                check_value("ch0", exp_ch0.pop_front(), got0);
                check_value("ch1", exp_ch1.pop_front(), got1);
                check_value("latency", LATENCY, cycle - issued);
            end
        end
    end

    // ******************************
    // stimulus
    task automatic stream(int t);
        sample_t s0;
        sample_t s1;
        logic    vld;
        int      e0;
        int      e1;
        for (int i = 0; i < count_tab[t]; i++) begin
            vld = 1'b1;
            case (src_tab[t])
                SRC_IMPULSE: begin
                    s0 = (i == 0) ? 16'sd1 : 16'sd0;
                    s1 = s0;
                end
                SRC_STEP: begin
                    s0 = 16'sh7fff; // full scale both ways.
                    s1 = 16'sh8000;
                end
                default: begin
                    lcg_state = lcg_next(lcg_state);
                    s0        = lcg_state[31:16];
                    lcg_state = lcg_next(lcg_state);
                    s1        = lcg_state[31:16];
                    if (src_tab[t] == SRC_RAND_GAP) begin
                        lcg_state = lcg_next(lcg_state);
                        vld       = (lcg_state[31:30] != 2'b00);
                    end
                end
            endcase
            smp.valid   = vld;
            smp.data[0] = s0;
            smp.data[1] = s1;
            if (vld && en_tab[t] != 0) begin
                model_shift(s0, s1);
                if (src_tab[t] == SRC_IMPULSE) begin
                    e0 = (i < TAPS) ? coef_tab[t][i] : 0; // response is the taps.
                    e1 = e0;
                end else begin
                    e0 = model_out(0, t);
                    e1 = model_out(1, t);
                end
                exp_ch0.push_back(e0);
                exp_ch1.push_back(e1);
                exp_cyc.push_back(cycle);
                out_beats++;
            end
            @(posedge clk_i);
            #2;
        end
        smp = '0;
    endtask

    task automatic wait_drain();
        int n;
        for (n = 0; n < DRAIN_TIMEOUT && exp_cyc.size() != 0; n++) begin
            @(posedge clk_i);
            #2;
        end
        if (exp_cyc.size() != 0) abort_run("output drain");
        repeat (2 * LATENCY) begin
            @(posedge clk_i); // quiet time, catches stray beats.
            #2;
        end
    endtask

    task automatic begin_test(string name);
        cur_test    = name;
        test_errors = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == test_errors) begin
            $display("test %-12s ok", cur_test);
        end else begin
            $display("test %-12s failed with %0d errors", cur_test, errors - test_errors);
            tests_failed++;
        end
    endtask

    task automatic load_table();
        name_tab[0] = "impulse";
        coef_tab[0] = '{1, -2, 300, -4000, 5000, -600, 70, 32767};
        name_tab[1] = "rand_dense";
        coef_tab[1] = '{600, -1700, 7500, 15000, 15000, 7500, -1700, 600};
        name_tab[2] = "rand_gaps";
        coef_tab[2] = '{-100000, 2000, 0, 131071, -131072, 5, -7, 40000};
        name_tab[3] = "saturation";
        coef_tab[3] = '{131071, 131071, 131071, 131071, 131071, 131071, 131071, 131071};
        name_tab[4] = "enable_off";
        coef_tab[4] = coef_tab[1];
        name_tab[5] = "enable_on";
        coef_tab[5] = coef_tab[1];
        shift_tab   = '{0, 15, 15, 0, 15, 15};
        en_tab      = '{1, 1, 1, 1, 0, 1};
        src_tab     = '{SRC_IMPULSE, SRC_RAND, SRC_RAND_GAP, SRC_STEP, SRC_RAND, SRC_RAND};
        count_tab   = '{12, 200, 200, 16, 24, 40};
    endtask

    task automatic run_entry(int t);
        logic [31:0] ctrl;
        begin_test(name_tab[t]);
        for (int k = 0; k < TAPS; k++) begin
            axil_write(REG_COEF_BASE + 12'(4 * k), 32'(coef_tab[t][k]), resp);
            check_value("coef bresp", RESP_OKAY, resp);
        end
        for (int k = 0; k < TAPS; k++) begin
            axil_read(REG_COEF_BASE + 12'(4 * k), rd_data, resp);
            check_value("coef readback", coef_tab[t][k], rd_data);
            check_value("coef rresp", RESP_OKAY, resp);
        end
        ctrl = 32'(en_tab[t]) | (32'(shift_tab[t]) << 8);
        axil_write(REG_CTRL, ctrl, resp);
        check_value("ctrl bresp", RESP_OKAY, resp);
        if (src_tab[t] == SRC_STEP) begin
            axil_write(REG_STATUS, 32'd1, resp);
            axil_read(REG_STATUS, rd_data, resp);
            check_value("sat flag before", 0, rd_data[0]);
        end
        stream(t);
        wait_drain();
        if (src_tab[t] == SRC_STEP) begin
            axil_read(REG_STATUS, rd_data, resp);
            check_value("sat flag set", 1, rd_data[0]);
            axil_write(REG_STATUS, 32'd1, resp);
            axil_read(REG_STATUS, rd_data, resp);
            check_value("sat flag cleared", 0, rd_data[0]);
        end
        end_test();
    endtask

    initial begin
        rst_i    = 1'b1;
        axil_req = '0;
        smp      = '0;
        load_table();
        repeat (16) @(posedge clk_i);
        #2;
        rst_i = 1'b0;

        begin_test("csr_errors");
        axil_write(REG_COEF_BASE + 12'(4 * TAPS), 32'd5, resp);
        check_value("tap 8 bresp", RESP_SLVERR, resp);
        axil_read(REG_COEF_BASE + 12'(4 * TAPS), rd_data, resp);
        check_value("tap 8 rresp", RESP_SLVERR, resp);
        check_value("tap 8 rdata", 0, rd_data);
        axil_write(12'h008, 32'hffff_ffff, resp);
        check_value("unmapped bresp", RESP_SLVERR, resp);
        axil_read(12'h008, rd_data, resp);
        check_value("unmapped rresp", RESP_SLVERR, resp);
        check_value("unmapped rdata", 0, rd_data);
        axil_read(12'hffc, rd_data, resp);
        check_value("top rresp", RESP_SLVERR, resp);
        check_value("top rdata", 0, rd_data);
        end_test();

        for (int t = 0; t < N_TESTS; t++) begin
            run_entry(t);
        end

        begin_test("out_count");
        axil_read(REG_STATUS, rd_data, resp);
        check_value("count", out_beats % 65536, rd_data[31:16]);
        end_test();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
logic/fir_pkg.sv
logic/fir_csr.sv
logic/fir_coef_bank.sv
logic/fir_channel.sv
logic/fir_out_scale.sv
logic/fir_top.sv
dv/fir_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the FIR testbench with Verilator and run it.
# The run fails when the log holds the fail message.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module fir_tb -f sim.f -o fir_sim \
    && ./obj_dir/fir_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "FAILED"; exit 1; } || echo "PASSED"
